// File: src.f
+incdir+include
rtl/ex_cfg_pkg.sv
rtl/ex_op_pkg.sv
rtl/ex_int_alu.sv
rtl/ex_hilo_unit.sv
rtl/ex_result_stage.sv
rtl/ex_stage.sv
tests/ex_stage_tb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - rtl/ex_cfg_pkg.sv
      - rtl/ex_op_pkg.sv
      - rtl/ex_int_alu.sv
      - rtl/ex_hilo_unit.sv
      - rtl/ex_result_stage.sv
      - rtl/ex_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/ex_stage_tb.sv

// File: include/ex_tb_vectors.svh
`ifndef EX_TB_VECTORS_SVH
`define EX_TB_VECTORS_SVH

// one table entry, stimulus first and then the expected result
typedef struct packed {
    ex_op_pkg::alu_op_e    aluop;
    ex_op_pkg::alu_sel_e   alusel;
    ex_cfg_pkg::word_t     reg1;
    ex_cfg_pkg::word_t     reg2;
    logic [REG_ADDR_W-1:0] wd;
    logic                  wreg;
    ex_cfg_pkg::word_t     exp_wdata;
    logic                  exp_wreg;
} vec_t;

vec_t vec_q[$];

task automatic add_vec(
    input ex_op_pkg::alu_op_e    op,
    input ex_op_pkg::alu_sel_e   sel,
    input ex_cfg_pkg::word_t     r1,
    input ex_cfg_pkg::word_t     r2,
    input logic [REG_ADDR_W-1:0] wd,
    input logic                  wreg,
    input ex_cfg_pkg::word_t     exp_d,
    input logic                  exp_w
);
    vec_t v;
    v.aluop     = op;
    v.alusel    = sel;
    v.reg1      = r1;
    v.reg2      = r2;
    v.wd        = wd;
    v.wreg      = wreg;
    v.exp_wdata = exp_d;
    v.exp_wreg  = exp_w;
    vec_q.push_back(v);
endtask

task automatic load_vectors();
    // bitwise group
    add_vec(ex_op_pkg::OP_OR, ex_op_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0F0F_00FF,
            5'd1, 1'b1, 32'hFFFF_12FF, 1'b1);
    add_vec(ex_op_pkg::OP_AND, ex_op_pkg::SEL_LOGIC, 32'hF0F0_1234, 32'h0FFF_00FF,
            5'd2, 1'b1, 32'h00F0_0034, 1'b1);
    add_vec(ex_op_pkg::OP_NOR, ex_op_pkg::SEL_LOGIC, 32'hF0F0_0000, 32'h0000_0F0F,
            5'd3, 1'b1, 32'h0F0F_F0F0, 1'b1);
    add_vec(ex_op_pkg::OP_XOR, ex_op_pkg::SEL_LOGIC, 32'hAAAA_5555, 32'hFFFF_0000,
            5'd4, 1'b1, 32'h5555_5555, 1'b1);
    // shift amount is reg1[4:0], upper bits ignored
    add_vec(ex_op_pkg::OP_SLL, ex_op_pkg::SEL_SHIFT, 32'h0000_0024, 32'h0000_00F1,
            5'd5, 1'b1, 32'h0000_0F10, 1'b1);
    add_vec(ex_op_pkg::OP_SRL, ex_op_pkg::SEL_SHIFT, 32'hFFFF_FFE8, 32'h8000_1200,
            5'd6, 1'b1, 32'h0080_0012, 1'b1);
    add_vec(ex_op_pkg::OP_SRA, ex_op_pkg::SEL_SHIFT, 32'h0000_0004, 32'h8000_0000,
            5'd7, 1'b1, 32'hF800_0000, 1'b1);
    add_vec(ex_op_pkg::OP_SRA, ex_op_pkg::SEL_SHIFT, 32'h0000_0021, 32'hF000_0010,
            5'd8, 1'b1, 32'hF800_0008, 1'b1);
    // add/sub, signed overflow drops the write
    add_vec(ex_op_pkg::OP_ADD, ex_op_pkg::SEL_ARITH, 32'h0000_0005, 32'h0000_0007,
            5'd9, 1'b1, 32'h0000_000C, 1'b1);
    add_vec(ex_op_pkg::OP_ADD, ex_op_pkg::SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0001,
            5'd10, 1'b1, 32'h8000_0000, 1'b0);
    add_vec(ex_op_pkg::OP_ADDU, ex_op_pkg::SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0001,
            5'd11, 1'b1, 32'h8000_0000, 1'b1);
    add_vec(ex_op_pkg::OP_ADDI, ex_op_pkg::SEL_ARITH, 32'h8000_0000, 32'hFFFF_FFFF,
            5'd12, 1'b1, 32'h7FFF_FFFF, 1'b0);
    add_vec(ex_op_pkg::OP_ADDIU, ex_op_pkg::SEL_ARITH, 32'hFFFF_FFF0, 32'h0000_0020,
            5'd13, 1'b1, 32'h0000_0010, 1'b1);
    add_vec(ex_op_pkg::OP_SUB, ex_op_pkg::SEL_ARITH, 32'h0000_0010, 32'h0000_0003,
            5'd14, 1'b1, 32'h0000_000D, 1'b1);
    add_vec(ex_op_pkg::OP_SUB, ex_op_pkg::SEL_ARITH, 32'h8000_0000, 32'h0000_0001,
            5'd15, 1'b1, 32'h7FFF_FFFF, 1'b0);
    add_vec(ex_op_pkg::OP_SUBU, ex_op_pkg::SEL_ARITH, 32'h0000_0000, 32'h0000_0001,
            5'd16, 1'b1, 32'hFFFF_FFFF, 1'b1);
    add_vec(ex_op_pkg::OP_ADDU, ex_op_pkg::SEL_ARITH, 32'h0000_0003, 32'h0000_0004,
            5'd17, 1'b0, 32'h0000_0007, 1'b0);
    // -1 vs 1, signed and unsigned disagree
    add_vec(ex_op_pkg::OP_SLT, ex_op_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'h0000_0001,
            5'd18, 1'b1, 32'h0000_0001, 1'b1);
    add_vec(ex_op_pkg::OP_SLTU, ex_op_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'h0000_0001,
            5'd19, 1'b1, 32'h0000_0000, 1'b1);
    // leading bit counts
    add_vec(ex_op_pkg::OP_CLZ, ex_op_pkg::SEL_ARITH, 32'h0000_0000, 32'h0000_0000,
            5'd20, 1'b1, 32'h0000_0020, 1'b1);
    add_vec(ex_op_pkg::OP_CLZ, ex_op_pkg::SEL_ARITH, 32'h8000_0000, 32'h0000_0000,
            5'd21, 1'b1, 32'h0000_0000, 1'b1);
    add_vec(ex_op_pkg::OP_CLZ, ex_op_pkg::SEL_ARITH, 32'h0001_0000, 32'h0000_0000,
            5'd22, 1'b1, 32'h0000_000F, 1'b1);
    add_vec(ex_op_pkg::OP_CLO, ex_op_pkg::SEL_ARITH, 32'hFFFF_FFFF, 32'h0000_0000,
            5'd23, 1'b1, 32'h0000_0020, 1'b1);
    add_vec(ex_op_pkg::OP_CLO, ex_op_pkg::SEL_ARITH, 32'h7FFF_FFFF, 32'h0000_0000,
            5'd24, 1'b1, 32'h0000_0000, 1'b1);
    add_vec(ex_op_pkg::OP_CLO, ex_op_pkg::SEL_ARITH, 32'hFF00_0000, 32'h0000_0000,
            5'd25, 1'b1, 32'h0000_0008, 1'b1);
    // HI/LO writes give a zero result, later reads return them
    add_vec(ex_op_pkg::OP_MTHI, ex_op_pkg::SEL_MOVE, 32'h1234_5678, 32'h0000_0000,
            5'd26, 1'b0, 32'h0000_0000, 1'b0);
    add_vec(ex_op_pkg::OP_MTLO, ex_op_pkg::SEL_MOVE, 32'h9ABC_DEF0, 32'h0000_0000,
            5'd27, 1'b0, 32'h0000_0000, 1'b0);
    add_vec(ex_op_pkg::OP_MFHI, ex_op_pkg::SEL_MOVE, 32'h0000_0000, 32'h0000_0000,
            5'd28, 1'b1, 32'h1234_5678, 1'b1);
    add_vec(ex_op_pkg::OP_MFLO, ex_op_pkg::SEL_MOVE, 32'h0000_0000, 32'h0000_0000,
            5'd29, 1'b1, 32'h9ABC_DEF0, 1'b1);
    add_vec(ex_op_pkg::OP_MOVZ, ex_op_pkg::SEL_MOVE, 32'hCAFE_0001, 32'h0000_0000,
            5'd30, 1'b1, 32'hCAFE_0001, 1'b1);
    add_vec(ex_op_pkg::OP_MOVN, ex_op_pkg::SEL_MOVE, 32'h0BAD_F00D, 32'h0000_0001,
            5'd31, 1'b1, 32'h0BAD_F00D, 1'b1);
    add_vec(ex_op_pkg::OP_NOP, ex_op_pkg::SEL_NOP, 32'hFFFF_FFFF, 32'hFFFF_FFFF,
            5'd0, 1'b0, 32'h0000_0000, 1'b0);  // none class gives zero
endtask

`endif

// File: tests/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    localparam int REG_ADDR_W     = 5;
    localparam int HALF_PERIOD    = 4;
    localparam int DRIVE_DLY      = 1;   // inputs change just after the rising edge
    localparam int RESET_CYCLES   = 10;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int TAIL_CYCLES    = 20;  // idle window after the last item
    localparam logic [31:0] SEED  = 32'h22a6ae7c;

    logic                  clk;
    logic                  rst_n_i;
    logic                  in_valid_i;
    logic                  in_ready_o;
    ex_op_pkg::alu_op_e    aluop_i;
    ex_op_pkg::alu_sel_e   alusel_i;
    ex_cfg_pkg::word_t     reg1_i;
    ex_cfg_pkg::word_t     reg2_i;
    logic [REG_ADDR_W-1:0] wd_i;
    logic                  wreg_i;
    logic                  out_valid_o;
    logic                  out_ready_i;
    logic [REG_ADDR_W-1:0] wd_o;
    logic                  wreg_o;
    ex_cfg_pkg::word_t     wdata_o;

    int   passed;
    int   failed;
    int   other_errs;  // timeouts and stray outputs
    logic mon_done;

    `include "ex_tb_vectors.svh"

    ex_stage #(
        .REG_ADDR_W (REG_ADDR_W)
    ) dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .aluop_i     (aluop_i),
        .alusel_i    (alusel_i),
        .reg1_i      (reg1_i),
        .reg2_i      (reg2_i),
        .wd_i        (wd_i),
        .wreg_i      (wreg_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .wd_o        (wd_o),
        .wreg_o      (wreg_o),
        .wdata_o     (wdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // presents each entry and holds it until the stage takes it
    task automatic drive_items();
        int   waited;
        logic accepted;
        @(posedge clk);
        foreach (vec_q[i]) begin
            #(DRIVE_DLY);
            in_valid_i = 1'b1;
            aluop_i    = vec_q[i].aluop;
            alusel_i   = vec_q[i].alusel;
            reg1_i     = vec_q[i].reg1;
            reg2_i     = vec_q[i].reg2;
            wd_i       = vec_q[i].wd;
            wreg_i     = vec_q[i].wreg;
            accepted   = 1'b0;
            waited     = 0;
            while (!accepted && waited < TIMEOUT_CYCLES) begin
                @(negedge clk);
                accepted = in_ready_o;  // taken at the coming rising edge
                @(posedge clk);
                waited++;
            end
            if (!accepted) begin
                $display("driver gave up: in_ready_o never rose for test %0d", i);
                other_errs++;
                break;
            end
        end
        #(DRIVE_DLY);
        in_valid_i = 1'b0;
    endtask

    // random back-pressure until the monitor is finished
    task automatic toggle_ready();
        while (!mon_done) begin
            @(posedge clk);
            #(DRIVE_DLY);
            out_ready_i = (($urandom % 4) != 0);
        end
    endtask

    task automatic check_outputs();
        int   waited;
        logic seen;
        logic ok;
        logic stray;
        foreach (vec_q[i]) begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < TIMEOUT_CYCLES) begin
                @(negedge clk);
                seen = out_valid_o && out_ready_i;
                waited++;
            end
            if (!seen) begin
                $display("monitor gave up: no output transfer for test %0d", i);
                other_errs++;
                break;
            end
            ok = 1'b1;
            if (wdata_o !== vec_q[i].exp_wdata) begin
                $display("MISMATCH at %0t: test %0d wdata_o %h, expected %h",
                         $time, i, wdata_o, vec_q[i].exp_wdata);
                ok = 1'b0;
            end
            if (wreg_o !== vec_q[i].exp_wreg) begin
                $display("MISMATCH at %0t: test %0d wreg_o %b, expected %b",
                         $time, i, wreg_o, vec_q[i].exp_wreg);
                ok = 1'b0;
            end
            if (wd_o !== vec_q[i].wd) begin
                $display("MISMATCH at %0t: test %0d wd_o %0d, expected %0d",
                         $time, i, wd_o, vec_q[i].wd);
                ok = 1'b0;
            end
            if (ok) begin
                passed++;
                $display("test %0d op %h ok", i, vec_q[i].aluop);
            end else begin
                failed++;
                $display("test %0d op %h wrong result", i, vec_q[i].aluop);
            end
        end
        // table is exhausted, the stage must stay empty
        stray = 1'b0;
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            if (out_valid_o) begin
                stray = 1'b1;
            end
        end
        if (stray) begin
            $display("an output item appeared after the last table entry");
            other_errs++;
        end
        mon_done = 1'b1;
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i     = 1'b0;
        in_valid_i  = 1'b0;
        aluop_i     = ex_op_pkg::OP_NOP;
        alusel_i    = ex_op_pkg::SEL_NOP;
        reg1_i      = '0;
        reg2_i      = '0;
        wd_i        = '0;
        wreg_i      = 1'b0;
        out_ready_i = 1'b0;
        passed      = 0;
        failed      = 0;
        other_errs  = 0;
        mon_done    = 1'b0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst_n_i = 1'b1;
        fork
            drive_items();
            check_outputs();
            toggle_ready();
        join
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 vec_q.size(), passed, failed, other_errs);
        if (failed == 0 && other_errs == 0 && passed == vec_q.size()) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // from decode
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  ex_op_pkg::alu_op_e    aluop_i,
    input  ex_op_pkg::alu_sel_e   alusel_i,
    input  ex_cfg_pkg::word_t     reg1_i,
    input  ex_cfg_pkg::word_t     reg2_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  wreg_i,
    // to memory stage
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output ex_cfg_pkg::word_t     wdata_o
);

    ex_cfg_pkg::word_t alu_result;
    ex_cfg_pkg::word_t move_result;
    logic              ov;
    logic              accept;  // also the HI/LO write strobe

    ex_int_alu int_alu0 (
        .aluop_i      (aluop_i),
        .alusel_i     (alusel_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .alu_result_o (alu_result),
        .ov_o         (ov)
    );

    ex_hilo_unit hilo0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .accept_i      (accept),
        .aluop_i       (aluop_i),
        .reg1_i        (reg1_i),
        .move_result_o (move_result)
    );

    ex_result_stage #(
        .REG_ADDR_W (REG_ADDR_W)
    ) result0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (in_valid_i),
        .alusel_i      (alusel_i),
        .alu_result_i  (alu_result),
        .move_result_i (move_result),
        .ov_i          (ov),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .out_ready_i   (out_ready_i),
        .in_ready_o    (in_ready_o),
        .accept_o      (accept),
        .out_valid_o   (out_valid_o),
        .wd_o          (wd_o),
        .wreg_o        (wreg_o),
        .wdata_o       (wdata_o)
    );

endmodule

// File: rtl/ex_result_stage.sv
`timescale 1ns/1ps

module ex_result_stage #(
    parameter int REG_ADDR_W = 5
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  in_valid_i,
    input  ex_op_pkg::alu_sel_e   alusel_i,
    input  ex_cfg_pkg::word_t     alu_result_i,
    input  ex_cfg_pkg::word_t     move_result_i,
    input  logic                  ov_i,
    input  logic [REG_ADDR_W-1:0] wd_i,
    input  logic                  wreg_i,
    input  logic                  out_ready_i,
    output logic                  in_ready_o,
    output logic                  accept_o,
    output logic                  out_valid_o,
    output logic [REG_ADDR_W-1:0] wd_o,
    output logic                  wreg_o,
    output ex_cfg_pkg::word_t     wdata_o
);

    ex_cfg_pkg::word_t wdata_d;
    logic              valid_q;

    // free slot, or the held item leaves this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign accept_o   = in_valid_i && in_ready_o;

    always_comb begin
        case (alusel_i)
            ex_op_pkg::SEL_MOVE: wdata_d = move_result_i;
            ex_op_pkg::SEL_NOP:  wdata_d = ex_cfg_pkg::ZERO_WORD;
            default:             wdata_d = alu_result_i;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;  // drained, or refilled in the same cycle
        end
    end

    // payload register, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (accept_o) begin
            wd_o    <= wd_i;
            wreg_o  <= wreg_i && !ov_i;  // signed overflow cancels the write
            wdata_o <= wdata_d;
        end
    end

    assign out_valid_o = valid_q;

    // stalled output keeps its payload until taken
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (out_valid_o && !out_ready_i) |=>
            (out_valid_o && $stable(wd_o) && $stable(wreg_o) && $stable(wdata_o))
    ) else $error("output payload changed under back-pressure");

    a_rst_no_valid: assert property (
        @(posedge clk) !rst_n_i |-> !out_valid_o
    ) else $error("out_valid_o high during reset");

endmodule

// File: rtl/ex_hilo_unit.sv
`timescale 1ns/1ps

module ex_hilo_unit (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               accept_i,  // item taken by the result stage
    input  ex_op_pkg::alu_op_e aluop_i,
    input  ex_cfg_pkg::word_t  reg1_i,
    output ex_cfg_pkg::word_t  move_result_o
);

    ex_cfg_pkg::word_t hi_q;
    ex_cfg_pkg::word_t lo_q;
    logic              wr_hi;
    logic              wr_lo;

    // writes land only on the accepting edge
    assign wr_hi = accept_i && (aluop_i == ex_op_pkg::OP_MTHI);
    assign wr_lo = accept_i && (aluop_i == ex_op_pkg::OP_MTLO);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hi_q <= ex_cfg_pkg::ZERO_WORD;
            lo_q <= ex_cfg_pkg::ZERO_WORD;
        end else begin
            if (wr_hi) begin
                hi_q <= reg1_i;
            end
            if (wr_lo) begin
                lo_q <= reg1_i;
            end
        end
    end

    // reads see the registered values, so a later mfhi gets the new HI
    always_comb begin
        case (aluop_i)
            ex_op_pkg::OP_MFHI: move_result_o = hi_q;
            ex_op_pkg::OP_MFLO: move_result_o = lo_q;
            ex_op_pkg::OP_MOVZ,
            ex_op_pkg::OP_MOVN: move_result_o = reg1_i;  // condition checked in decode
            default:            move_result_o = '0;
        endcase
    end

    // HI/LO only move when the result stage takes an item
    a_hilo_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !accept_i |=> ($stable(hi_q) && $stable(lo_q))
    ) else $error("HI/LO changed without accept");

endmodule

// File: rtl/ex_int_alu.sv
`timescale 1ns/1ps

module ex_int_alu (
    input  ex_op_pkg::alu_op_e  aluop_i,
    input  ex_op_pkg::alu_sel_e alusel_i,
    input  ex_cfg_pkg::word_t   reg1_i,
    input  ex_cfg_pkg::word_t   reg2_i,
    output ex_cfg_pkg::word_t   alu_result_o,
    output logic                ov_o
);

    localparam int MSB   = ex_cfg_pkg::DATA_W - 1;
    localparam int CNT_W = $clog2(ex_cfg_pkg::DATA_W) + 1;  // must hold DATA_W itself

    ex_cfg_pkg::word_t logic_res;
    ex_cfg_pkg::word_t shift_res;
    ex_cfg_pkg::word_t arith_res;
    ex_cfg_pkg::word_t opnd2;     // reg2 or its two's complement
    ex_cfg_pkg::word_t sum;
    ex_cfg_pkg::word_t lead_src;  // reg1, inverted for clo
    logic [CNT_W-1:0]  lead_cnt;
    logic [ex_cfg_pkg::SHAMT_W-1:0] shamt;
    logic              use_neg;
    logic              ov_sum;
    logic              reg1_lt_reg2;

    // logic group
    always_comb begin
        case (aluop_i)
            ex_op_pkg::OP_OR:  logic_res = reg1_i | reg2_i;
            ex_op_pkg::OP_AND: logic_res = reg1_i & reg2_i;
            ex_op_pkg::OP_NOR: logic_res = ~(reg1_i | reg2_i);
            ex_op_pkg::OP_XOR: logic_res = reg1_i ^ reg2_i;
            default:           logic_res = '0;
        endcase
    end

    assign shamt = reg1_i[ex_cfg_pkg::SHAMT_W-1:0];

    always_comb begin
        case (aluop_i)
            ex_op_pkg::OP_SLL: shift_res = reg2_i << shamt;
            ex_op_pkg::OP_SRL: shift_res = reg2_i >> shamt;
            ex_op_pkg::OP_SRA: shift_res = $signed(reg2_i) >>> shamt;  // sign fill
            default:           shift_res = '0;
        endcase
    end

    // one adder for add, sub and the signed compare
    assign use_neg = (aluop_i == ex_op_pkg::OP_SUB) ||
                     (aluop_i == ex_op_pkg::OP_SUBU) ||
                     (aluop_i == ex_op_pkg::OP_SLT);
    assign opnd2 = use_neg ? (~reg2_i + 1'b1) : reg2_i;
    assign sum   = reg1_i + opnd2;

    // same-sign operands giving a result of the other sign
    assign ov_sum = (!reg1_i[MSB] && !opnd2[MSB] && sum[MSB]) ||
                    (reg1_i[MSB] && opnd2[MSB] && !sum[MSB]);

    assign ov_o = ov_sum && ((aluop_i == ex_op_pkg::OP_ADD) ||
                             (aluop_i == ex_op_pkg::OP_ADDI) ||
                             (aluop_i == ex_op_pkg::OP_SUB));

    // signed: neg < pos, or same signs and a negative difference
    assign reg1_lt_reg2 = (aluop_i == ex_op_pkg::OP_SLT) ?
                          ((reg1_i[MSB] && !reg2_i[MSB]) ||
                           (!reg1_i[MSB] && !reg2_i[MSB] && sum[MSB]) ||
                           (reg1_i[MSB] && reg2_i[MSB] && sum[MSB])) :
                          (reg1_i < reg2_i);

    // leading ones of reg1 are leading zeros of its inverse
    assign lead_src = (aluop_i == ex_op_pkg::OP_CLO) ? ~reg1_i : reg1_i;

    // priority encoder, the highest set bit wins
    always_comb begin
        lead_cnt = CNT_W'(ex_cfg_pkg::DATA_W);
        for (int i = 0; i < ex_cfg_pkg::DATA_W; i++) begin
            if (lead_src[i]) begin
                lead_cnt = CNT_W'(MSB - i);
            end
        end
    end

    always_comb begin
        case (aluop_i)
            ex_op_pkg::OP_SLT,
            ex_op_pkg::OP_SLTU: begin
                arith_res = {{(ex_cfg_pkg::DATA_W-1){1'b0}}, reg1_lt_reg2};
            end
            ex_op_pkg::OP_ADD,
            ex_op_pkg::OP_ADDU,
            ex_op_pkg::OP_ADDI,
            ex_op_pkg::OP_ADDIU,
            ex_op_pkg::OP_SUB,
            ex_op_pkg::OP_SUBU: begin
                arith_res = sum;  // modulo sum, ov handled downstream
            end
            ex_op_pkg::OP_CLZ,
            ex_op_pkg::OP_CLO: begin
                arith_res = {{(ex_cfg_pkg::DATA_W-CNT_W){1'b0}}, lead_cnt};
            end
            default: begin
                arith_res = '0;
            end
        endcase
    end

    // move class is served by the HI/LO unit
    always_comb begin
        case (alusel_i)
            ex_op_pkg::SEL_LOGIC: alu_result_o = logic_res;
            ex_op_pkg::SEL_SHIFT: alu_result_o = shift_res;
            ex_op_pkg::SEL_ARITH: alu_result_o = arith_res;
            default:              alu_result_o = '0;
        endcase
    end

endmodule

// File: rtl/ex_op_pkg.sv
package ex_op_pkg;

    // operation subtype, same codes as the decode stage
    typedef enum logic [7:0] {
        OP_NOP   = 8'b0000_0000,
        // logic group
        OP_OR    = 8'b0010_0101,
        OP_AND   = 8'b0010_0100,
        OP_NOR   = 8'b0010_0111,
        OP_XOR   = 8'b0010_0110,
        // shifts
        OP_SLL   = 8'b0111_1100,
        OP_SRL   = 8'b0000_0010,
        OP_SRA   = 8'b0000_0011,
        // add / sub
        OP_ADD   = 8'b0010_0000,
        OP_ADDU  = 8'b0010_0001,
        OP_SUB   = 8'b0010_0010,
        OP_SUBU  = 8'b0010_0011,
        OP_ADDI  = 8'b0101_0101,
        OP_ADDIU = 8'b0101_0110,
        // compares
        OP_SLT   = 8'b0010_1010,
        OP_SLTU  = 8'b0010_1011,
        // leading bit counts
        OP_CLZ   = 8'b1011_0000,
        OP_CLO   = 8'b1011_0001,
        // moves
        OP_MOVZ  = 8'b0000_1010,
        OP_MOVN  = 8'b0000_1011,
        OP_MFHI  = 8'b0001_0000,
        OP_MTHI  = 8'b0001_0001,
        OP_MFLO  = 8'b0001_0010,
        OP_MTLO  = 8'b0001_0011
    } alu_op_e;

    // result class, picks which unit feeds wdata
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_MOVE  = 3'b011,
        SEL_ARITH = 3'b100
    } alu_sel_e;

endpackage

// File: rtl/ex_cfg_pkg.sv
package ex_cfg_pkg;

    // data path width
    localparam int DATA_W  = 32;
    localparam int SHAMT_W = 5;  // shift amount field, low bits of reg1

    typedef logic [DATA_W-1:0] word_t;

    // reset value for HI/LO and the none result class
    localparam word_t ZERO_WORD = '0;

endpackage
